/* rtl/prga_pkg.sv */
package prga_pkg;

    typedef logic [7:0] byte_t;

    typedef enum logic [4:0] {
        IDLE,
        LEN_RD,     // ct[0] address out
        LEN_WAIT,
        LEN_WR,     // pt[0] = L
        CHECK,
        STEP_I,
        RD_SI,
        WAIT_SI,
        STEP_J,
        RD_SJ,
        WAIT_SJ,
        WR_J,       // S[j] = old S[i]
        WR_I,       // S[i] = old S[j]
        RD_PAD,
        WAIT_PAD,
        XOR_WR,
        NEXT_K,
        DONE
    } prga_state_e;

    typedef enum logic [1:0] {
        SEL_I,
        SEL_J,
        SEL_PAD
    } s_sel_e;

    typedef struct packed {
        byte_t addr;
        byte_t wrdata;
        logic  wren;
    } s_port_t;

    typedef struct packed {
        byte_t addr;
        byte_t wrdata;
        logic  wren;
    } pt_port_t;

    // one control word per state
    typedef struct packed {
        logic   step_i;
        logic   step_j;
        logic   step_k;
        logic   capture_len;
        logic   capture_si;
        logic   capture_sj;
        logic   capture_pad;
        s_sel_e s_sel;
        logic   s_wren;
        logic   pt_len_wr;
        logic   pt_xor_wr;
    } prga_ctrl_t;

endpackage

/* rtl/prga_ctrl.sv */
`timescale 1ns/1ps

module prga_ctrl #(
    parameter bit RST_ASSERT = 1'b1
) (
    input  logic                 clk,
    input  logic                 rst_i,
    input  logic                 en_i,
    input  logic                 last_i,
    output prga_pkg::prga_ctrl_t ctrl_o,
    output logic                 rdy_o
);

    prga_pkg::prga_state_e state_q;
    prga_pkg::prga_state_e state_d;

    always_ff @(posedge clk) begin
        if (rst_i || !en_i) begin
            state_q <= prga_pkg::IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            prga_pkg::IDLE:     state_d = en_i ? prga_pkg::LEN_RD : prga_pkg::IDLE;
            prga_pkg::LEN_RD:   state_d = prga_pkg::LEN_WAIT;
            prga_pkg::LEN_WAIT: state_d = prga_pkg::LEN_WR;
            prga_pkg::LEN_WR:   state_d = prga_pkg::CHECK;
            prga_pkg::CHECK:    state_d = last_i ? prga_pkg::DONE : prga_pkg::STEP_I;
            prga_pkg::STEP_I:   state_d = prga_pkg::RD_SI;
            prga_pkg::RD_SI:    state_d = prga_pkg::WAIT_SI;
            prga_pkg::WAIT_SI:  state_d = prga_pkg::STEP_J;
            prga_pkg::STEP_J:   state_d = prga_pkg::RD_SJ;
            prga_pkg::RD_SJ:    state_d = prga_pkg::WAIT_SJ;
            prga_pkg::WAIT_SJ:  state_d = prga_pkg::WR_J;
            prga_pkg::WR_J:     state_d = prga_pkg::WR_I;
            prga_pkg::WR_I:     state_d = prga_pkg::RD_PAD;
            prga_pkg::RD_PAD:   state_d = prga_pkg::WAIT_PAD;
            prga_pkg::WAIT_PAD: state_d = prga_pkg::XOR_WR;
            prga_pkg::XOR_WR:   state_d = prga_pkg::NEXT_K;
            prga_pkg::NEXT_K:   state_d = prga_pkg::CHECK;
            prga_pkg::DONE:     state_d = prga_pkg::DONE;   // held until en_i drops
            default:            state_d = prga_pkg::IDLE;
        endcase
    end

    // Moore decode, all fields default low
    always_comb begin
        ctrl_o = '0;
        ctrl_o.s_sel = prga_pkg::SEL_I;
        unique case (state_q)
            prga_pkg::LEN_WAIT: begin
                ctrl_o.capture_len = 1'b1;
            end
            prga_pkg::LEN_WR: begin
                ctrl_o.pt_len_wr = 1'b1;
            end
            prga_pkg::STEP_I: begin
                ctrl_o.step_i = 1'b1;
            end
            prga_pkg::WAIT_SI: begin
                ctrl_o.capture_si = 1'b1;
            end
            prga_pkg::STEP_J: begin
                ctrl_o.step_j = 1'b1;               // rddata still S[i]
            end
            prga_pkg::RD_SJ: begin
                ctrl_o.s_sel = prga_pkg::SEL_J;
            end
            prga_pkg::WAIT_SJ: begin
                ctrl_o.s_sel = prga_pkg::SEL_J;
                ctrl_o.capture_sj = 1'b1;
            end
            prga_pkg::WR_J: begin
                ctrl_o.s_sel = prga_pkg::SEL_J;
                ctrl_o.s_wren = 1'b1;
            end
            prga_pkg::WR_I: begin
                ctrl_o.s_wren = 1'b1;
            end
            prga_pkg::RD_PAD: begin
                ctrl_o.s_sel = prga_pkg::SEL_PAD;
            end
            prga_pkg::WAIT_PAD: begin
                ctrl_o.s_sel = prga_pkg::SEL_PAD;
                ctrl_o.capture_pad = 1'b1;
            end
            prga_pkg::XOR_WR: begin
                ctrl_o.pt_xor_wr = 1'b1;
            end
            prga_pkg::NEXT_K: begin
                ctrl_o.step_k = 1'b1;
            end
            default: begin
                ctrl_o.s_sel = prga_pkg::SEL_I;
            end
        endcase
    end

    assign rdy_o = (state_q == prga_pkg::DONE);

    generate
        if (RST_ASSERT) begin : g_assert
            // one memory write per cycle across S and pt
            a_one_write: assert property (@(posedge clk) disable iff (rst_i)
                !(ctrl_o.s_wren && (ctrl_o.pt_len_wr || ctrl_o.pt_xor_wr)));

            // done means quiet
            a_rdy_quiet: assert property (@(posedge clk) disable iff (rst_i)
                rdy_o |-> !ctrl_o.s_wren && !ctrl_o.pt_len_wr && !ctrl_o.pt_xor_wr);
        end
    endgenerate

endmodule

/* rtl/prga_index_unit.sv */
`timescale 1ns/1ps

module prga_index_unit #(
    parameter int MEM_DEPTH  = 256,
    parameter bit RST_ASSERT = 1'b1
) (
    input  logic                 clk,
    input  logic                 rst_i,
    input  logic                 en_i,
    input  prga_pkg::prga_ctrl_t ctrl_i,
    input  prga_pkg::byte_t      s_rddata_i,
    input  prga_pkg::byte_t      ct_rddata_i,
    output prga_pkg::byte_t      i_o,
    output prga_pkg::byte_t      j_o,
    output prga_pkg::byte_t      k_o,
    output prga_pkg::byte_t      len_o,
    output logic                 last_o
);

    localparam prga_pkg::byte_t IDX_MASK = prga_pkg::byte_t'(MEM_DEPTH - 1);

    prga_pkg::byte_t i_q;
    prga_pkg::byte_t j_q;
    prga_pkg::byte_t len_q;
    logic [8:0]      k_q;       // extra bit so L = 255 still terminates

    always_ff @(posedge clk) begin
        if (rst_i || !en_i) begin
            i_q   <= '0;
            j_q   <= '0;
            k_q   <= 9'd1;
            len_q <= '0;
        end else begin
            if (ctrl_i.step_i) begin
                i_q <= (i_q + 8'd1) & IDX_MASK;
            end
            if (ctrl_i.step_j) begin
                j_q <= (j_q + s_rddata_i) & IDX_MASK;   // j += S[i]
            end
            if (ctrl_i.step_k) begin
                k_q <= k_q + 9'd1;
            end
            if (ctrl_i.capture_len) begin
                len_q <= ct_rddata_i;   // ct[0]
            end
        end
    end

    assign last_o = (k_q > {1'b0, len_q});

    assign i_o   = i_q;
    assign j_o   = j_q;
    assign k_o   = k_q[7:0];
    assign len_o = len_q;

    generate
        if (RST_ASSERT) begin : g_assert
            a_k_bound: assert property (@(posedge clk) disable iff (rst_i)
                k_q <= {1'b0, len_q} + 9'd1);
        end
    endgenerate

endmodule

/* rtl/prga_byte_path.sv */
`timescale 1ns/1ps

module prga_byte_path #(
    parameter int MEM_DEPTH = 256
) (
    input  logic                 clk,
    input  logic                 rst_i,
    input  logic                 en_i,
    input  prga_pkg::prga_ctrl_t ctrl_i,
    input  prga_pkg::byte_t      i_i,
    input  prga_pkg::byte_t      j_i,
    input  prga_pkg::byte_t      k_i,
    input  prga_pkg::byte_t      len_i,
    input  prga_pkg::byte_t      s_rddata_i,
    input  prga_pkg::byte_t      ct_rddata_i,
    output prga_pkg::s_port_t    s_o,
    output prga_pkg::byte_t      ct_addr_o,
    output prga_pkg::pt_port_t   pt_o
);

    localparam prga_pkg::byte_t IDX_MASK = prga_pkg::byte_t'(MEM_DEPTH - 1);

    prga_pkg::byte_t si_q;
    prga_pkg::byte_t sj_q;
    prga_pkg::byte_t pad_q;
    prga_pkg::byte_t pad_addr;
    logic            len_seen_q;     // ct[0] already read

    always_ff @(posedge clk) begin
        if (rst_i || !en_i) begin
            si_q  <= '0;
            sj_q  <= '0;
            pad_q <= '0;
        end else begin
            if (ctrl_i.capture_si) begin
                si_q <= s_rddata_i;
            end
            if (ctrl_i.capture_sj) begin
                sj_q <= s_rddata_i;
            end
            if (ctrl_i.capture_pad) begin
                pad_q <= s_rddata_i;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i || !en_i) begin
            len_seen_q <= 1'b0;
        end else if (ctrl_i.capture_len) begin
            len_seen_q <= 1'b1;
        end
    end

    // S[i] and S[j] here are the values before the swap
    assign pad_addr = (si_q + sj_q) & IDX_MASK;

    always_comb begin
        s_o.wren = ctrl_i.s_wren;
        unique case (ctrl_i.s_sel)
            prga_pkg::SEL_I: begin
                s_o.addr   = i_i;
                s_o.wrdata = sj_q;      // S[i] gets old S[j]
            end
            prga_pkg::SEL_J: begin
                s_o.addr   = j_i;
                s_o.wrdata = si_q;      // S[j] gets old S[i]
            end
            default: begin
                s_o.addr   = pad_addr;
                s_o.wrdata = '0;
            end
        endcase
    end

    // ct[k] is addressed for the whole step, so rddata is ready at XOR_WR
    assign ct_addr_o = len_seen_q ? k_i : '0;

    always_comb begin
        pt_o.wren = ctrl_i.pt_len_wr || ctrl_i.pt_xor_wr;
        if (ctrl_i.pt_len_wr) begin
            pt_o.addr   = '0;
            pt_o.wrdata = len_i;
        end else begin
            pt_o.addr   = k_i;
            pt_o.wrdata = pad_q ^ ct_rddata_i;
        end
    end

endmodule

/* rtl/prga_top.sv */
`timescale 1ns/1ps

module prga_top #(
    parameter int MEM_DEPTH  = 256,
    parameter bit RST_ASSERT = 1'b1
) (
    input  logic               clk,
    input  logic               rst_i,
    input  logic               en_i,
    input  prga_pkg::byte_t    s_rddata_i,
    input  prga_pkg::byte_t    ct_rddata_i,
    output prga_pkg::s_port_t  s_o,
    output prga_pkg::byte_t    ct_addr_o,
    output prga_pkg::pt_port_t pt_o,
    output logic               rdy_o
);

    prga_pkg::prga_ctrl_t ctrl;
    logic                 last;
    prga_pkg::byte_t      i_idx;
    prga_pkg::byte_t      j_idx;
    prga_pkg::byte_t      k_idx;
    prga_pkg::byte_t      len;

    prga_ctrl #(
        .RST_ASSERT (RST_ASSERT)
    ) ctrl_i (
        .clk    (clk),
        .rst_i  (rst_i),
        .en_i   (en_i),
        .last_i (last),
        .ctrl_o (ctrl),
        .rdy_o  (rdy_o)
    );

    prga_index_unit #(
        .MEM_DEPTH  (MEM_DEPTH),
        .RST_ASSERT (RST_ASSERT)
    ) index_i (
        .clk         (clk),
        .rst_i       (rst_i),
        .en_i        (en_i),
        .ctrl_i      (ctrl),
        .s_rddata_i  (s_rddata_i),
        .ct_rddata_i (ct_rddata_i),
        .i_o         (i_idx),
        .j_o         (j_idx),
        .k_o         (k_idx),
        .len_o       (len),
        .last_o      (last)
    );

    prga_byte_path #(
        .MEM_DEPTH (MEM_DEPTH)
    ) byte_path_i (
        .clk         (clk),
        .rst_i       (rst_i),
        .en_i        (en_i),
        .ctrl_i      (ctrl),
        .i_i         (i_idx),
        .j_i         (j_idx),
        .k_i         (k_idx),
        .len_i       (len),
        .s_rddata_i  (s_rddata_i),
        .ct_rddata_i (ct_rddata_i),
        .s_o         (s_o),
        .ct_addr_o   (ct_addr_o),
        .pt_o        (pt_o)
    );

endmodule

/* tb/prga_mem_model.sv */
`timescale 1ns/1ps

module prga_mem_model #(
    parameter int MEM_DEPTH = 256
) (
    input  logic               clk,
    input  prga_pkg::s_port_t  s_i,
    output prga_pkg::byte_t    s_rddata_o,
    input  prga_pkg::byte_t    ct_addr_i,
    output prga_pkg::byte_t    ct_rddata_o,
    input  prga_pkg::pt_port_t pt_i
);

    prga_pkg::byte_t s_mem  [MEM_DEPTH];
    prga_pkg::byte_t ct_mem [256];
    prga_pkg::byte_t pt_mem [256];

    int s_wr_count  = 0;     // write log
    int pt_wr_count = 0;

    // read data is the old entry on a same-cycle write
    always @(posedge clk) begin
        s_rddata_o <= s_mem[s_i.addr];
        if (s_i.wren) begin
            s_mem[s_i.addr] <= s_i.wrdata;
            s_wr_count      <= s_wr_count + 1;
        end
    end

    always @(posedge clk) begin
        ct_rddata_o <= ct_mem[ct_addr_i];
    end

    always @(posedge clk) begin
        if (pt_i.wren) begin
            pt_mem[pt_i.addr] <= pt_i.wrdata;
            pt_wr_count       <= pt_wr_count + 1;
        end
    end

endmodule

/* tb/prga_tb.sv */
`timescale 1ns/1ps

module prga_tb;

    localparam int MEM_DEPTH      = 256;
    localparam int LEN_FIRST      = 45;
    localparam int LEN_EMPTY      = 0;
    localparam int LEN_RESTART    = 20;
    localparam int RUN_BYTES      = (LEN_FIRST + 1) + (LEN_EMPTY + 1) + (LEN_RESTART + 1);
    localparam int TIMEOUT_CYCLES = 40 * RUN_BYTES + 200;

    logic               clk = 1'b0;
    logic               rst;
    logic               en;
    prga_pkg::byte_t    s_rddata;
    prga_pkg::byte_t    ct_rddata;
    prga_pkg::s_port_t  s_req;
    prga_pkg::byte_t    ct_addr;
    prga_pkg::pt_port_t pt_req;
    logic               rdy;

    integer             seed;
    prga_pkg::byte_t    ref_s  [MEM_DEPTH];  // RC4 model state
    prga_pkg::byte_t    exp_pt [256];
    prga_pkg::byte_t    exp_len = '0;
    int                 wr_idx  = 0;
    int                 cycles  = 0;
    logic               rst_q   = 1'b0;
    logic               en_q    = 1'b1;
    logic               rdy_q   = 1'b0;

    always #2 clk = ~clk;

    prga_top #(
        .MEM_DEPTH  (MEM_DEPTH),
        .RST_ASSERT (1'b1)
    ) prga_top_i (
        .clk         (clk),
        .rst_i       (rst),
        .en_i        (en),
        .s_rddata_i  (s_rddata),
        .ct_rddata_i (ct_rddata),
        .s_o         (s_req),
        .ct_addr_o   (ct_addr),
        .pt_o        (pt_req),
        .rdy_o       (rdy)
    );

    prga_mem_model #(
        .MEM_DEPTH (MEM_DEPTH)
    ) mem_i (
        .clk         (clk),
        .s_i         (s_req),
        .s_rddata_o  (s_rddata),
        .ct_addr_i   (ct_addr),
        .ct_rddata_o (ct_rddata),
        .pt_i        (pt_req)
    );

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    // Fisher-Yates over 0..MEM_DEPTH-1
    task automatic shuffle_s();
        int n;
        int r;
        prga_pkg::byte_t tmp;
        for (n = 0; n < MEM_DEPTH; n++) begin
            ref_s[n] = prga_pkg::byte_t'(n);
        end
        for (n = MEM_DEPTH - 1; n > 0; n--) begin
            r = int'($unsigned($random(seed)) % (n + 1));
            tmp      = ref_s[n];
            ref_s[n] = ref_s[r];
            ref_s[r] = tmp;
        end
        for (n = 0; n < MEM_DEPTH; n++) begin
            mem_i.s_mem[n] = ref_s[n];
        end
    endtask

    // advances ref_s the same way the decryptor advances S
    task automatic compute_reference(input int len);
        int i;
        int j;
        int k;
        prga_pkg::byte_t tmp;
        i = 0;
        j = 0;
        exp_len   = prga_pkg::byte_t'(len);
        exp_pt[0] = prga_pkg::byte_t'(len);
        for (k = 1; k <= len; k++) begin
            i        = (i + 1) % MEM_DEPTH;
            j        = (j + ref_s[i]) % MEM_DEPTH;
            tmp      = ref_s[i];
            ref_s[i] = ref_s[j];
            ref_s[j] = tmp;
            exp_pt[k] = mem_i.ct_mem[k] ^ ref_s[(ref_s[i] + ref_s[j]) % MEM_DEPTH];
        end
    endtask

    task automatic run_message(input int len);
        int n;
        mem_i.ct_mem[0] = prga_pkg::byte_t'(len);
        for (n = 1; n <= len; n++) begin
            mem_i.ct_mem[n] = prga_pkg::byte_t'($random(seed));
        end
        compute_reference(len);
        en = 1'b1;
        while (!rdy) begin
            @(negedge clk);
        end
        repeat (3) @(negedge clk);      // rdy must hold here
        en = 1'b0;
        repeat (3) @(negedge clk);
    endtask

    always @(posedge clk) begin : check_outputs
        int n;
        rst_q <= rst;
        en_q  <= en;
        rdy_q <= rdy;
        if (rst_q || !en_q) begin
            assert (!rdy) else report_failure("rdy_o is high while in reset or not enabled");
        end
        if (rdy_q && en_q) begin
            assert (rdy) else report_failure("rdy_o dropped while en_i was still high");
        end
        if (!en) begin
            wr_idx <= 0;
        end else if (pt_req.wren) begin
            assert (wr_idx <= int'(exp_len))
                else report_failure("pt write after the last byte of the message");
            assert (pt_req.addr == prga_pkg::byte_t'(wr_idx))
                else report_failure($sformatf("Mismatch pt_o.addr: got %h expected %h",
                                              pt_req.addr, prga_pkg::byte_t'(wr_idx)));
            assert (pt_req.wrdata == exp_pt[wr_idx])
                else report_failure($sformatf("Mismatch pt_o.wrdata at %h: got %h expected %h",
                                              pt_req.addr, pt_req.wrdata, exp_pt[wr_idx]));
            wr_idx <= wr_idx + 1;
        end
        if (rdy && !rdy_q) begin
            assert (wr_idx == int'(exp_len) + 1)
                else report_failure($sformatf("rdy_o rose after %0d pt writes instead of %0d",
                                              wr_idx, int'(exp_len) + 1));
            for (n = 0; n < MEM_DEPTH; n++) begin
                assert (mem_i.s_mem[n] == ref_s[n])
                    else report_failure($sformatf("Mismatch S[%h]: got %h expected %h",
                                                  n[7:0], mem_i.s_mem[n], ref_s[n]));
            end
            for (n = 0; n <= int'(exp_len); n++) begin
                assert (mem_i.pt_mem[n] == exp_pt[n])
                    else report_failure($sformatf("Mismatch pt[%h]: got %h expected %h",
                                                  n[7:0], mem_i.pt_mem[n], exp_pt[n]));
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > TIMEOUT_CYCLES) begin
            report_failure($sformatf("timeout, no finish after %0d cycles", cycles));
        end
    end

    initial begin
        rst  = 1'b1;
        en   = 1'b0;
        seed = 32'h0f72c70b;
        shuffle_s();
        repeat (3) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        run_message(LEN_FIRST);
        run_message(LEN_EMPTY);
        run_message(LEN_RESTART);   // restarts from the permuted S
        if (mem_i.pt_wr_count != RUN_BYTES) begin
            report_failure($sformatf("Mismatch pt write count: got %h expected %h",
                                     mem_i.pt_wr_count, RUN_BYTES));
        end else if (mem_i.s_wr_count != 2 * (RUN_BYTES - 3)) begin
            report_failure($sformatf("Mismatch S write count: got %h expected %h",
                                     mem_i.s_wr_count, 2 * (RUN_BYTES - 3)));
        end else begin
            $display("Simulation PASSED");
            $finish;
        end
    end

endmodule

/* sources.f */
rtl/prga_pkg.sv
rtl/prga_ctrl.sv
rtl/prga_index_unit.sv
rtl/prga_byte_path.sv
rtl/prga_top.sv
tb/prga_mem_model.sv
tb/prga_tb.sv

/* Makefile */
VERILATOR ?= verilator
FILELIST  ?= sources.f
TOP       ?= prga_tb
RTL_TOP   ?= prga_top
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
TIMESCALE ?= 1ns/1ps
VFLAGS    ?= --binary --timing --assert --timescale $(TIMESCALE)
LINTFLAGS ?= --lint-only --timescale $(TIMESCALE)

SOURCES   := $(shell cat $(FILELIST))
RTL_SRCS  := $(shell grep '^rtl/' $(FILELIST))

.PHONY: all build run lint clean

all: run

build: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Simulation PASSED" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) $(RTL_SRCS) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
